//--- logic/aluDecoder.sv
// ALU decoder
// Operation class and funct fields to the ALU control code
`timescale 1ns/1ns
`default_nettype none

module aluDecoder (
    input  ctrlPkg::aluOpT    aluOp,
    decodeBus.alu             dec,
    output ctrlPkg::aluCtrlT  aluControl
);

    logic rTypeSub;

    // Sub only for R-type with funct7 bit 5 set
    // I-type addi ignores that bit
    assign rTypeSub = (dec.instrClass == riscvIsaPkg::clsRType) && dec.funct7b5;

    always_comb
    begin
        case (aluOp)
            ctrlPkg::aluOpAdd: aluControl = ctrlPkg::aluAdd;
            ctrlPkg::aluOpSub: aluControl = ctrlPkg::aluSub;
            ctrlPkg::aluOpFunct:
            begin
                case (dec.funct3)
                    riscvIsaPkg::f3AddSub:
                    begin
                        aluControl = rTypeSub ? ctrlPkg::aluSub : ctrlPkg::aluAdd;
                    end
                    riscvIsaPkg::f3Slt: aluControl = ctrlPkg::aluSlt;
                    riscvIsaPkg::f3Or:  aluControl = ctrlPkg::aluOr;
                    riscvIsaPkg::f3And: aluControl = ctrlPkg::aluAnd;
                    // Unsupported funct3 falls back to add
                    default:            aluControl = ctrlPkg::aluAdd;
                endcase
            end
            default: aluControl = ctrlPkg::aluAdd;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/controlUnit.sv
// Multicycle RV32I control unit top level
// Instruction decoder, main FSM and ALU decoder around one decode bus
`timescale 1ns/1ns
`default_nettype none

module controlUnit (
    input  logic                clk,
    input  logic                reset,
    input  riscvIsaPkg::opcodeT op,
    input  riscvIsaPkg::funct3T funct3,
    input  logic                funct7b5,
    input  logic                zero,
    output logic                pcWrite,
    output logic                adrSrc,
    output logic                memWrite,
    output logic                irWrite,
    output logic                regWrite,
    output ctrlPkg::resultSrcT  resultSrc,
    output ctrlPkg::aluSrcAT    aluSrcA,
    output ctrlPkg::aluSrcBT    aluSrcB,
    output ctrlPkg::immSrcT     immSrc,
    output ctrlPkg::aluCtrlT    aluControl
);

    // Operation class from the FSM
    ctrlPkg::aluOpT aluOp;

    decodeBus bus ();

    instrDecoder decoder (
        .op       (op),
        .funct3   (funct3),
        .funct7b5 (funct7b5),
        .dec      (bus.decoder)
    );

    mainFsm fsm (
        .clk       (clk),
        .reset     (reset),
        .zero      (zero),
        .dec       (bus.fsm),
        .aluOp     (aluOp),
        .pcWrite   (pcWrite),
        .adrSrc    (adrSrc),
        .memWrite  (memWrite),
        .irWrite   (irWrite),
        .regWrite  (regWrite),
        .resultSrc (resultSrc),
        .aluSrcA   (aluSrcA),
        .aluSrcB   (aluSrcB)
    );

    aluDecoder aluDec (
        .aluOp      (aluOp),
        .dec        (bus.alu),
        .aluControl (aluControl)
    );

    // Immediate format goes straight to the extender
    assign immSrc = bus.immSrc;

endmodule

`default_nettype wire

//--- logic/ctrlPkg.sv
// Control unit definitions
// FSM state encoding, mux select codes, ALU operation class and ALU codes
`default_nettype none

package ctrlPkg;

    // Working states 0 to 11, trap parked at 15
    typedef enum logic [3:0] {
        stReset    = 4'd0,
        stFetch    = 4'd1,
        stDecode   = 4'd2,
        stMemAddr  = 4'd3,
        stMemRead  = 4'd4,
        stMemWb    = 4'd5,
        stMemWrite = 4'd6,
        stExecR    = 4'd7,
        stExecI    = 4'd8,
        stAluWb    = 4'd9,
        stJal      = 4'd10,
        stBeq      = 4'd11,
        stTrap     = 4'd15
    } ctrlStateT;

    // ALU operand A select
    typedef logic [1:0] aluSrcAT;
    localparam aluSrcAT srcAPc    = 2'd0;
    localparam aluSrcAT srcAOldPc = 2'd1;
    localparam aluSrcAT srcARs1   = 2'd2;

    // ALU operand B select
    typedef logic [1:0] aluSrcBT;
    localparam aluSrcBT srcBRs2  = 2'd0;
    localparam aluSrcBT srcBImm  = 2'd1;
    localparam aluSrcBT srcBFour = 2'd2;

    // Result bus select
    typedef logic [1:0] resultSrcT;
    localparam resultSrcT resAluOut    = 2'd0;
    localparam resultSrcT resMemData   = 2'd1;
    localparam resultSrcT resAluResult = 2'd2;

    // Immediate format for the extender
    typedef logic [1:0] immSrcT;
    localparam immSrcT immI = 2'd0;
    localparam immSrcT immS = 2'd1;
    localparam immSrcT immB = 2'd2;
    localparam immSrcT immJ = 2'd3;

    // Operation class from the FSM to the ALU decoder
    typedef enum logic [1:0] {
        aluOpAdd   = 2'd0,
        aluOpSub   = 2'd1,
        aluOpFunct = 2'd2
    } aluOpT;

    // ALU control codes
    typedef logic [2:0] aluCtrlT;
    localparam aluCtrlT aluAdd = 3'b000;
    localparam aluCtrlT aluSub = 3'b001;
    localparam aluCtrlT aluAnd = 3'b010;
    localparam aluCtrlT aluOr  = 3'b011;
    localparam aluCtrlT aluSlt = 3'b101;

endpackage

`default_nettype wire

//--- logic/decodeBus.sv
// Decoded instruction fields
// Shared by the instruction decoder, the FSM and the ALU decoder
`timescale 1ns/1ns
`default_nettype none

interface decodeBus;

    riscvIsaPkg::instrClassT instrClass;
    ctrlPkg::immSrcT         immSrc;
    riscvIsaPkg::funct3T     funct3;
    logic                    funct7b5;

    // Decoder owns every field
    modport decoder (output instrClass, immSrc, funct3, funct7b5);
    // FSM only branches on the class
    modport fsm (input instrClass);
    // ALU decoder needs class plus funct bits
    modport alu (input instrClass, funct3, funct7b5);

endinterface

`default_nettype wire

//--- logic/instrDecoder.sv
// Instruction decoder
// Opcode classification and immediate format select
`timescale 1ns/1ns
`default_nettype none

module instrDecoder (
    input  riscvIsaPkg::opcodeT op,
    input  riscvIsaPkg::funct3T funct3,
    input  logic                funct7b5,
    decodeBus.decoder           dec
);

    riscvIsaPkg::instrClassT instrClass;
    ctrlPkg::immSrcT         immSrc;

    // Opcode to class, anything unknown is illegal
    always_comb
    begin
        case (op)
            riscvIsaPkg::opLoad:   instrClass = riscvIsaPkg::clsLoad;
            riscvIsaPkg::opStore:  instrClass = riscvIsaPkg::clsStore;
            riscvIsaPkg::opRType:  instrClass = riscvIsaPkg::clsRType;
            riscvIsaPkg::opIType:  instrClass = riscvIsaPkg::clsIType;
            riscvIsaPkg::opJal:    instrClass = riscvIsaPkg::clsJal;
            riscvIsaPkg::opBranch: instrClass = riscvIsaPkg::clsBranch;
            riscvIsaPkg::opNop:    instrClass = riscvIsaPkg::clsNop;
            default:               instrClass = riscvIsaPkg::clsIllegal;
        endcase
    end

    // Immediate format per class
    // I format also covers R-type, nop and illegal
    always_comb
    begin
        case (instrClass)
            riscvIsaPkg::clsStore:  immSrc = ctrlPkg::immS;
            riscvIsaPkg::clsBranch: immSrc = ctrlPkg::immB;
            riscvIsaPkg::clsJal:    immSrc = ctrlPkg::immJ;
            default:                immSrc = ctrlPkg::immI;
        endcase
    end

    assign dec.instrClass = instrClass;
    assign dec.immSrc     = immSrc;
    // Funct bits pass straight through for the ALU decoder
    assign dec.funct3     = funct3;
    assign dec.funct7b5   = funct7b5;

endmodule

`default_nettype wire

//--- logic/mainFsm.sv
// Multicycle main FSM
// State register, next-state logic and Moore control outputs
// Branch PC write in beq follows the zero flag
`timescale 1ns/1ns
`default_nettype none

module mainFsm (
    input  logic               clk,
    input  logic               reset,
    input  logic               zero,
    decodeBus.fsm              dec,
    output ctrlPkg::aluOpT     aluOp,
    output logic               pcWrite,
    output logic               adrSrc,
    output logic               memWrite,
    output logic               irWrite,
    output logic               regWrite,
    output ctrlPkg::resultSrcT resultSrc,
    output ctrlPkg::aluSrcAT   aluSrcA,
    output ctrlPkg::aluSrcBT   aluSrcB
);

    ctrlPkg::ctrlStateT state;
    ctrlPkg::ctrlStateT nextState;

    // State register
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= ctrlPkg::stReset;
        end
        else
        begin
            state <= nextState;
        end
    end

    // Next state
    always_comb
    begin
        case (state)
            ctrlPkg::stReset:   nextState = ctrlPkg::stFetch;
            ctrlPkg::stFetch:   nextState = ctrlPkg::stDecode;
            ctrlPkg::stDecode:
            begin
                // Dispatch on the held instruction class
                case (dec.instrClass)
                    riscvIsaPkg::clsLoad:   nextState = ctrlPkg::stMemAddr;
                    riscvIsaPkg::clsStore:  nextState = ctrlPkg::stMemAddr;
                    riscvIsaPkg::clsRType:  nextState = ctrlPkg::stExecR;
                    riscvIsaPkg::clsIType:  nextState = ctrlPkg::stExecI;
                    riscvIsaPkg::clsJal:    nextState = ctrlPkg::stJal;
                    riscvIsaPkg::clsBranch: nextState = ctrlPkg::stBeq;
                    riscvIsaPkg::clsNop:    nextState = ctrlPkg::stFetch;
                    default:                nextState = ctrlPkg::stTrap;
                endcase
            end
            ctrlPkg::stMemAddr:
            begin
                // Load reads, store writes
                if (dec.instrClass == riscvIsaPkg::clsLoad)
                begin
                    nextState = ctrlPkg::stMemRead;
                end
                else
                begin
                    nextState = ctrlPkg::stMemWrite;
                end
            end
            ctrlPkg::stMemRead:  nextState = ctrlPkg::stMemWb;
            ctrlPkg::stMemWb:    nextState = ctrlPkg::stFetch;
            ctrlPkg::stMemWrite: nextState = ctrlPkg::stFetch;
            ctrlPkg::stExecR:    nextState = ctrlPkg::stAluWb;
            ctrlPkg::stExecI:    nextState = ctrlPkg::stAluWb;
            // Jal writes the link address through the ALU writeback state
            ctrlPkg::stJal:      nextState = ctrlPkg::stAluWb;
            ctrlPkg::stAluWb:    nextState = ctrlPkg::stFetch;
            ctrlPkg::stBeq:      nextState = ctrlPkg::stFetch;
            // Trap holds until reset, unused codes fall in here too
            default:             nextState = ctrlPkg::stTrap;
        endcase
    end

    // Moore outputs, defaults are all enables low and selects zero
    always_comb
    begin
        pcWrite   = 1'b0;
        adrSrc    = 1'b0;
        memWrite  = 1'b0;
        irWrite   = 1'b0;
        regWrite  = 1'b0;
        resultSrc = ctrlPkg::resAluOut;
        aluSrcA   = ctrlPkg::srcAPc;
        aluSrcB   = ctrlPkg::srcBRs2;
        aluOp     = ctrlPkg::aluOpAdd;
        case (state)
            ctrlPkg::stFetch:
            begin
                // PC <- PC + 4, latch the instruction
                pcWrite   = 1'b1;
                irWrite   = 1'b1;
                aluSrcA   = ctrlPkg::srcAPc;
                aluSrcB   = ctrlPkg::srcBFour;
                resultSrc = ctrlPkg::resAluResult;
            end
            ctrlPkg::stDecode:
            begin
                // Branch or jump target from old PC plus immediate
                aluSrcA = ctrlPkg::srcAOldPc;
                aluSrcB = ctrlPkg::srcBImm;
            end
            ctrlPkg::stMemAddr:
            begin
                aluSrcA = ctrlPkg::srcARs1;
                aluSrcB = ctrlPkg::srcBImm;
            end
            ctrlPkg::stMemRead:
            begin
                adrSrc    = 1'b1;
                resultSrc = ctrlPkg::resAluOut;
            end
            ctrlPkg::stMemWb:
            begin
                resultSrc = ctrlPkg::resMemData;
                regWrite  = 1'b1;
            end
            ctrlPkg::stMemWrite:
            begin
                adrSrc   = 1'b1;
                memWrite = 1'b1;
            end
            ctrlPkg::stExecR:
            begin
                aluSrcA = ctrlPkg::srcARs1;
                aluSrcB = ctrlPkg::srcBRs2;
                aluOp   = ctrlPkg::aluOpFunct;
            end
            ctrlPkg::stExecI:
            begin
                aluSrcA = ctrlPkg::srcARs1;
                aluSrcB = ctrlPkg::srcBImm;
                aluOp   = ctrlPkg::aluOpFunct;
            end
            ctrlPkg::stAluWb:
            begin
                resultSrc = ctrlPkg::resAluOut;
                regWrite  = 1'b1;
            end
            ctrlPkg::stJal:
            begin
                // PC <- target from decode, ALU forms the link value
                pcWrite   = 1'b1;
                aluSrcA   = ctrlPkg::srcAOldPc;
                aluSrcB   = ctrlPkg::srcBFour;
                resultSrc = ctrlPkg::resAluOut;
            end
            ctrlPkg::stBeq:
            begin
                // Compare rs1 and rs2, take the branch on equal
                aluSrcA   = ctrlPkg::srcARs1;
                aluSrcB   = ctrlPkg::srcBRs2;
                aluOp     = ctrlPkg::aluOpSub;
                resultSrc = ctrlPkg::resAluOut;
                pcWrite   = zero;
            end
            default:
            begin
                // Reset and trap keep the defaults
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/riscvIsaPkg.sv
// RV32I instruction-set definitions
// Field widths, opcodes, ALU funct3 values and instruction classes
`default_nettype none

package riscvIsaPkg;

    // Instruction field widths
    localparam int opcodeWidth = 7;
    localparam int funct3Width = 3;

    typedef logic [opcodeWidth-1:0] opcodeT;
    typedef logic [funct3Width-1:0] funct3T;

    // Major opcodes handled by the multicycle datapath
    localparam opcodeT opLoad   = 7'b0000011;
    localparam opcodeT opStore  = 7'b0100011;
    localparam opcodeT opRType  = 7'b0110011;
    localparam opcodeT opIType  = 7'b0010011;
    localparam opcodeT opJal    = 7'b1101111;
    localparam opcodeT opBranch = 7'b1100011;
    // All-zero word treated as a nop
    localparam opcodeT opNop    = 7'b0000000;

    // Funct3 values the ALU decoder knows
    localparam funct3T f3AddSub = 3'b000;
    localparam funct3T f3Slt    = 3'b010;
    localparam funct3T f3Or     = 3'b110;
    localparam funct3T f3And    = 3'b111;

    // Instruction class after opcode decode
    typedef enum logic [2:0] {
        clsLoad,
        clsStore,
        clsRType,
        clsIType,
        clsJal,
        clsBranch,
        clsNop,
        clsIllegal
    } instrClassT;

endpackage

`default_nettype wire

//--- project.f
logic/riscvIsaPkg.sv
logic/ctrlPkg.sv
logic/decodeBus.sv
logic/instrDecoder.sv
logic/mainFsm.sv
logic/aluDecoder.sv
logic/controlUnit.sv
tests/controlUnitTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --top-module controlUnitTb -f project.f -o controlUnitTb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/controlUnitTb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$log"; then
    exit 1
fi
exit 0

//--- tests/controlUnitTb.sv
// Testbench for the multicycle control unit
// Stimulus table, reference state model, output checker and timeout
`timescale 1ns/1ns
`default_nettype none

module controlUnitTb;

    localparam int numRows = 19;
    localparam int resetCycles = 8;
    localparam int trapResetCycles = 3;

    // Reference model states in their own encoding
    typedef enum int {
        mReset, mFetch, mDecode, mMemAddr, mMemRead, mMemWb, mMemWrite,
        mExecR, mExecI, mAluWb, mJal, mBeq, mTrap
    } modelStateT;

    // One instruction per row
    // zeroSel 2 takes zero from the LFSR
    typedef struct packed {
        riscvIsaPkg::opcodeT op;
        riscvIsaPkg::funct3T funct3;
        logic                funct7b5;
        logic [1:0]          zeroSel;
        int                  cycles;
        ctrlPkg::aluCtrlT    aluCtrl;
        ctrlPkg::immSrcT     immSrc;
    } rowT;

    logic                clk;
    logic                reset;
    riscvIsaPkg::opcodeT op;
    riscvIsaPkg::funct3T funct3;
    logic                funct7b5;
    logic                zero;
    logic                pcWrite;
    logic                adrSrc;
    logic                memWrite;
    logic                irWrite;
    logic                regWrite;
    ctrlPkg::resultSrcT  resultSrc;
    ctrlPkg::aluSrcAT    aluSrcA;
    ctrlPkg::aluSrcBT    aluSrcB;
    ctrlPkg::immSrcT     immSrc;
    ctrlPkg::aluCtrlT    aluControl;

    rowT         rows [numRows];
    rowT         curRow;
    modelStateT  expState;
    logic        zeroNow;
    logic [31:0] lfsr;
    int          errors = 0;
    int          cycleCount = 0;
    int          timeoutLimit = 0;
    // Expected length of the instruction in flight, 0 when none
    int          pendingCycles = 0;
    // DUT cycles since its last irWrite pulse
    int          sinceFetch = 0;

    controlUnit uut (
        .clk        (clk),
        .reset      (reset),
        .op         (op),
        .funct3     (funct3),
        .funct7b5   (funct7b5),
        .zero       (zero),
        .pcWrite    (pcWrite),
        .adrSrc     (adrSrc),
        .memWrite   (memWrite),
        .irWrite    (irWrite),
        .regWrite   (regWrite),
        .resultSrc  (resultSrc),
        .aluSrcA    (aluSrcA),
        .aluSrcB    (aluSrcB),
        .immSrc     (immSrc),
        .aluControl (aluControl)
    );

    // 10 ns clock
    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Run limit from the table length
    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (timeoutLimit > 0 && cycleCount >= timeoutLimit)
        begin
            $display("Timeout after %0d cycles, the instruction sequence did not complete",
                     cycleCount);
            $display("Errors: %0d", errors);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // First state after decode for each opcode
    function automatic modelStateT decodeTarget(input riscvIsaPkg::opcodeT opIn);
        case (opIn)
            riscvIsaPkg::opLoad:   return mMemAddr;
            riscvIsaPkg::opStore:  return mMemAddr;
            riscvIsaPkg::opRType:  return mExecR;
            riscvIsaPkg::opIType:  return mExecI;
            riscvIsaPkg::opJal:    return mJal;
            riscvIsaPkg::opBranch: return mBeq;
            riscvIsaPkg::opNop:    return mFetch;
            default:               return mTrap;
        endcase
    endfunction

    function automatic modelStateT nextModelState(input modelStateT s,
                                                  input riscvIsaPkg::opcodeT opIn);
        case (s)
            mReset:   return mFetch;
            mFetch:   return mDecode;
            mDecode:  return decodeTarget(opIn);
            mMemAddr: return (opIn == riscvIsaPkg::opLoad) ? mMemRead : mMemWrite;
            mMemRead: return mMemWb;
            mExecR:   return mAluWb;
            mExecI:   return mAluWb;
            mJal:     return mAluWb;
            mTrap:    return mTrap;
            // Last state of each instruction
            default:  return mFetch;
        endcase
    endfunction

    // Enables pcWrite adrSrc memWrite irWrite regWrite then resultSrc aluSrcA aluSrcB
    function automatic logic [10:0] stateOutputs(input modelStateT s);
        case (s)
            mFetch:    return {5'b10010, 2'd2, 2'd0, 2'd2};
            mDecode:   return {5'b00000, 2'd0, 2'd1, 2'd1};
            mMemAddr:  return {5'b00000, 2'd0, 2'd2, 2'd1};
            mMemRead:  return {5'b01000, 2'd0, 2'd0, 2'd0};
            mMemWb:    return {5'b00001, 2'd1, 2'd0, 2'd0};
            mMemWrite: return {5'b01100, 2'd0, 2'd0, 2'd0};
            mExecR:    return {5'b00000, 2'd0, 2'd2, 2'd0};
            mExecI:    return {5'b00000, 2'd0, 2'd2, 2'd1};
            mAluWb:    return {5'b00001, 2'd0, 2'd0, 2'd0};
            mJal:      return {5'b10000, 2'd0, 2'd1, 2'd2};
            // pcWrite in beq comes from zero
            mBeq:      return {5'b00000, 2'd0, 2'd2, 2'd0};
            default:   return 11'd0;
        endcase
    endfunction

    task automatic checkValue(input string name, input int actual, input int expected);
        if (actual != expected)
        begin
            errors++;
            $display("error at %0t ns: %s = %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic checkOutputs();
        logic [10:0]      e;
        logic             ePc;
        ctrlPkg::aluCtrlT eAlu;
        e = stateOutputs(expState);
        ePc = (expState == mBeq) ? zeroNow : e[10];
        // Only execute and beq use the decoded ALU code
        eAlu = (expState inside {mExecR, mExecI, mBeq}) ? curRow.aluCtrl : ctrlPkg::aluAdd;
        checkValue("pcWrite", 32'(pcWrite), 32'(ePc));
        checkValue("adrSrc", 32'(adrSrc), 32'(e[9]));
        checkValue("memWrite", 32'(memWrite), 32'(e[8]));
        checkValue("irWrite", 32'(irWrite), 32'(e[7]));
        checkValue("regWrite", 32'(regWrite), 32'(e[6]));
        checkValue("resultSrc", 32'(resultSrc), 32'(e[5:4]));
        checkValue("aluSrcA", 32'(aluSrcA), 32'(e[3:2]));
        checkValue("aluSrcB", 32'(aluSrcB), 32'(e[1:0]));
        checkValue("immSrc", 32'(immSrc), 32'(curRow.immSrc));
        checkValue("aluControl", 32'(aluControl), 32'(eAlu));
    endtask

    // Cycles between two irWrite pulses of the DUT
    task automatic countInstrCycles();
        if (irWrite)
        begin
            if (pendingCycles > 0)
            begin
                checkValue("cycles per instruction", sinceFetch, pendingCycles);
            end
            pendingCycles = curRow.cycles;
            sinceFetch = 0;
        end
        sinceFetch++;
    endtask

    task automatic fillTable();
        rows[0]  = '{riscvIsaPkg::opLoad,   3'b000, 1'b0, 2'd0, 5, ctrlPkg::aluAdd, ctrlPkg::immI};
        rows[1]  = '{riscvIsaPkg::opStore,  3'b010, 1'b0, 2'd0, 4, ctrlPkg::aluAdd, ctrlPkg::immS};
        rows[2]  = '{riscvIsaPkg::opRType,  3'b000, 1'b0, 2'd0, 4, ctrlPkg::aluAdd, ctrlPkg::immI};
        rows[3]  = '{riscvIsaPkg::opRType,  3'b000, 1'b1, 2'd0, 4, ctrlPkg::aluSub, ctrlPkg::immI};
        rows[4]  = '{riscvIsaPkg::opRType,  3'b010, 1'b0, 2'd1, 4, ctrlPkg::aluSlt, ctrlPkg::immI};
        rows[5]  = '{riscvIsaPkg::opRType,  3'b110, 1'b0, 2'd0, 4, ctrlPkg::aluOr,  ctrlPkg::immI};
        rows[6]  = '{riscvIsaPkg::opRType,  3'b111, 1'b1, 2'd0, 4, ctrlPkg::aluAnd, ctrlPkg::immI};
        // Unsupported funct3 falls back to add
        rows[7]  = '{riscvIsaPkg::opRType,  3'b001, 1'b1, 2'd0, 4, ctrlPkg::aluAdd, ctrlPkg::immI};
        // addi ignores funct7b5
        rows[8]  = '{riscvIsaPkg::opIType,  3'b000, 1'b1, 2'd0, 4, ctrlPkg::aluAdd, ctrlPkg::immI};
        rows[9]  = '{riscvIsaPkg::opIType,  3'b100, 1'b0, 2'd0, 4, ctrlPkg::aluAdd, ctrlPkg::immI};
        rows[10] = '{riscvIsaPkg::opJal,    3'b000, 1'b0, 2'd0, 4, ctrlPkg::aluAdd, ctrlPkg::immJ};
        rows[11] = '{riscvIsaPkg::opBranch, 3'b000, 1'b0, 2'd1, 3, ctrlPkg::aluSub, ctrlPkg::immB};
        rows[12] = '{riscvIsaPkg::opBranch, 3'b000, 1'b0, 2'd0, 3, ctrlPkg::aluSub, ctrlPkg::immB};
        rows[13] = '{riscvIsaPkg::opBranch, 3'b000, 1'b0, 2'd2, 3, ctrlPkg::aluSub, ctrlPkg::immB};
        rows[14] = '{riscvIsaPkg::opNop,    3'b000, 1'b0, 2'd0, 2, ctrlPkg::aluAdd, ctrlPkg::immI};
        // Illegal opcode runs fetch and decode then 4 trap cycles
        rows[15] = '{7'b1110011,            3'b000, 1'b0, 2'd0, 6, ctrlPkg::aluAdd, ctrlPkg::immI};
        rows[16] = '{riscvIsaPkg::opIType,  3'b111, 1'b0, 2'd0, 4, ctrlPkg::aluAnd, ctrlPkg::immI};
        rows[17] = '{riscvIsaPkg::opBranch, 3'b000, 1'b0, 2'd2, 3, ctrlPkg::aluSub, ctrlPkg::immB};
        rows[18] = '{riscvIsaPkg::opLoad,   3'b000, 1'b0, 2'd2, 5, ctrlPkg::aluAdd, ctrlPkg::immI};
    endtask

    // Called on the rising edge that enters fetch
    task automatic applyRow(input int idx);
        curRow = rows[idx];
        if (curRow.zeroSel == 2'd2)
        begin
            lfsr = lfsrStep(lfsr);
            zeroNow = lfsr[0];
        end
        else
        begin
            zeroNow = curRow.zeroSel[0];
        end
        op <= curRow.op;
        funct3 <= curRow.funct3;
        funct7b5 <= curRow.funct7b5;
        zero <= zeroNow;
    endtask

    task automatic applyReset(input int n);
        reset <= 1'b1;
        expState = mReset;
        // No instruction in flight across a reset
        pendingCycles = 0;
        repeat (n)
        begin
            @(negedge clk);
            checkOutputs();
            @(posedge clk);
        end
        reset <= 1'b0;
        // Reset state holds one more cycle
        @(negedge clk);
        checkOutputs();
        @(posedge clk);
        expState = mFetch;
    endtask

    task automatic runRow(input int idx);
        int cycles;
        bit done;
        applyRow(idx);
        cycles = 0;
        done = 1'b0;
        while (!done)
        begin
            // Outputs settled mid-cycle
            @(negedge clk);
            checkOutputs();
            countInstrCycles();
            cycles++;
            @(posedge clk);
            expState = nextModelState(expState, curRow.op);
            if (expState == mFetch || (expState == mTrap && cycles >= curRow.cycles))
            begin
                done = 1'b1;
            end
        end
        // Trap only leaves through reset
        if (expState == mTrap)
        begin
            applyReset(trapResetCycles);
        end
    endtask

    initial
    begin
        reset = 1'b1;
        op = riscvIsaPkg::opNop;
        funct3 = 3'b000;
        funct7b5 = 1'b0;
        zero = 1'b0;
        zeroNow = 1'b0;
        lfsr = 32'h129d0a7b;
        curRow = '{riscvIsaPkg::opNop, 3'b000, 1'b0, 2'd0, 0, ctrlPkg::aluAdd, ctrlPkg::immI};
        fillTable();
        timeoutLimit = resetCycles + trapResetCycles + 2 + 20;
        for (int i = 0; i < numRows; i++)
        begin
            timeoutLimit += rows[i].cycles;
        end
        applyReset(resetCycles);
        for (int i = 0; i < numRows; i++)
        begin
            runRow(i);
        end
        // Closing fetch ends the last instruction
        @(negedge clk);
        checkOutputs();
        countInstrCycles();
        $display("Errors: %0d, cycles run: %0d", errors, cycleCount);
        if (errors == 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
